// ==== src/link_timing_pkg.sv ====
/*
  serial link timing
  uart bit period, spi sck divider, counter types and the
  state encodings shared by both uarts and the spi master
*/

package link_timing_pkg;

  // uart bit period in fpga_clk cycles
  localparam logic [31:0] CLKS_PER_BIT = 32'd20;
  // 8N1 framing
  localparam int UART_DATA_BITS = 8;
  // fpga_clk cycles per sck half period
  localparam int SPI_HALF_PERIOD = 2;

  typedef logic [4:0] baud_cnt_t;
  typedef logic [2:0] bit_idx_t;

  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_t;
  typedef enum logic {SPI_IDLE, SPI_SHIFT} spi_state_t;

endpackage

// ==== src/slm_cmd_pkg.sv ====
/*
  display command definitions
  link byte, spi frame layout and reply queue sizing
*/

package slm_cmd_pkg;

  // any byte on uart or spi
  typedef logic [7:0] cmd_byte_t;

  // frame is {address, data}, address sent first, msb first
  localparam int SPI_FRAME_BITS = 16;
  typedef logic [SPI_FRAME_BITS-1:0] spi_frame_t;

  localparam int REPLY_DEPTH = 4;
  typedef logic [$clog2(REPLY_DEPTH)-1:0] reply_ptr_t;

endpackage

// ==== src/spi_xfer_if.sv ====
/*
  spi register transaction
  one request strobe with its frame, answered by the miso byte
*/

`timescale 1ns/1ns

interface spi_xfer_if;

  // request side, frame held while start pulses
  logic                     start;
  slm_cmd_pkg::spi_frame_t  frame;
  // response side
  slm_cmd_pkg::cmd_byte_t   reply;
  logic                     reply_valid;
  logic                     busy;

  modport requester (output start, output frame, input reply, input reply_valid, input busy);
  modport responder (input start, input frame, output reply, output reply_valid, output busy);

endinterface

// ==== src/uart_rx.sv ====
/*
  8N1 uart receiver
  mid-bit sampling, one-cycle valid strobe in the middle of the stop bit
*/

`timescale 1ns/1ns

module uart_rx (
  input  logic                   fpga_clk,
  input  logic                   reset_all_cmd_w,
  input  logic                   rx_serial_i,
  output slm_cmd_pkg::cmd_byte_t rx_byte_o,
  output logic                   rx_valid_o
);

  logic [1:0]                  rx_sync_q;
  logic                        rx_bit;
  link_timing_pkg::uart_state_t state_q;
  link_timing_pkg::baud_cnt_t  baud_cnt_q;
  link_timing_pkg::bit_idx_t   bit_idx_q;
  logic                        bit_end;
  logic                        half_bit;
  slm_cmd_pkg::cmd_byte_t      rx_shreg_q;

  // sampled line after two flops
  assign rx_bit   = rx_sync_q[1];
  assign bit_end  = baud_cnt_q == link_timing_pkg::baud_cnt_t'(link_timing_pkg::CLKS_PER_BIT - 1);
  // middle of the start bit
  assign half_bit =
    baud_cnt_q == link_timing_pkg::baud_cnt_t'((link_timing_pkg::CLKS_PER_BIT - 1) / 2);

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // idle line is high
      rx_sync_q  <= 2'b11;
      state_q    <= link_timing_pkg::UART_IDLE;
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_sync_q  <= {rx_sync_q[0], rx_serial_i};
      rx_valid_o <= 1'b0;
      baud_cnt_q <= baud_cnt_q + 1'b1;
      case (state_q)
        link_timing_pkg::UART_IDLE: begin
          baud_cnt_q <= '0;
          bit_idx_q  <= '0;
          if (!rx_bit) state_q <= link_timing_pkg::UART_START;
        end
        link_timing_pkg::UART_START: begin
          // glitch check at half bit, re-align counter to bit centre
          if (half_bit) begin
            baud_cnt_q <= '0;
            state_q    <= rx_bit ? link_timing_pkg::UART_IDLE : link_timing_pkg::UART_DATA;
          end
        end
        link_timing_pkg::UART_DATA: begin
          if (bit_end) begin
            baud_cnt_q <= '0;
            bit_idx_q  <= bit_idx_q + 1'b1;
            if (bit_idx_q == link_timing_pkg::bit_idx_t'(link_timing_pkg::UART_DATA_BITS - 1))
              state_q <= link_timing_pkg::UART_STOP;
          end
        end
        default: begin
          // stop bit centre, strobe only on a good stop bit
          if (bit_end) begin
            rx_valid_o <= rx_bit;
            state_q    <= link_timing_pkg::UART_IDLE;
          end
        end
      endcase
    end
  end

  // lsb first into the top of the shifter
  always_ff @(posedge fpga_clk) begin
    if (state_q == link_timing_pkg::UART_DATA && bit_end)
      rx_shreg_q <= {rx_bit, rx_shreg_q[7:1]};
  end

  assign rx_byte_o = rx_shreg_q;

endmodule

// ==== src/uart_tx.sv ====
/*
  8N1 uart transmitter
  byte latched on start, busy until the stop bit ends
*/

`timescale 1ns/1ns

module uart_tx (
  input  logic                   fpga_clk,
  input  logic                   reset_all_cmd_w,
  input  slm_cmd_pkg::cmd_byte_t tx_byte_i,
  input  logic                   tx_start_i,
  output logic                   tx_busy_o,
  output logic                   tx_serial_o
);

  link_timing_pkg::uart_state_t state_q;
  link_timing_pkg::baud_cnt_t   baud_cnt_q;
  link_timing_pkg::bit_idx_t    bit_idx_q;
  logic                         bit_end;
  logic                         launch;
  slm_cmd_pkg::cmd_byte_t       tx_shreg_q;

  assign bit_end = baud_cnt_q == link_timing_pkg::baud_cnt_t'(link_timing_pkg::CLKS_PER_BIT - 1);
  assign launch  = (state_q == link_timing_pkg::UART_IDLE) && tx_start_i;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q     <= link_timing_pkg::UART_IDLE;
      baud_cnt_q  <= '0;
      bit_idx_q   <= '0;
      tx_serial_o <= 1'b1;
    end else if (state_q == link_timing_pkg::UART_IDLE) begin
      baud_cnt_q <= '0;
      bit_idx_q  <= '0;
      // start bit on the line the cycle after the strobe
      if (tx_start_i) begin
        state_q     <= link_timing_pkg::UART_START;
        tx_serial_o <= 1'b0;
      end
    end else if (!bit_end) begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end else begin
      baud_cnt_q <= '0;
      case (state_q)
        link_timing_pkg::UART_START: begin
          state_q     <= link_timing_pkg::UART_DATA;
          tx_serial_o <= tx_shreg_q[0];
        end
        link_timing_pkg::UART_DATA: begin
          bit_idx_q <= bit_idx_q + 1'b1;
          if (bit_idx_q == link_timing_pkg::bit_idx_t'(link_timing_pkg::UART_DATA_BITS - 1)) begin
            state_q     <= link_timing_pkg::UART_STOP;
            tx_serial_o <= 1'b1;
          end else begin
            tx_serial_o <= tx_shreg_q[0];
          end
        end
        default: state_q <= link_timing_pkg::UART_IDLE;
      endcase
    end
  end

  // lsb first, next bit always at position 0
  always_ff @(posedge fpga_clk) begin
    if (launch)
      tx_shreg_q <= tx_byte_i;
    else if (bit_end && state_q != link_timing_pkg::UART_STOP)
      tx_shreg_q <= {1'b0, tx_shreg_q[7:1]};
  end

  assign tx_busy_o = state_q != link_timing_pkg::UART_IDLE;

endmodule

// ==== src/cmd_assembler.sv ====
/*
  command assembler
  pairs uart bytes into {address, data} and launches one spi write per pair
*/

`timescale 1ns/1ns

module cmd_assembler (
  input  logic                   fpga_clk,
  input  logic                   reset_all_cmd_w,
  input  slm_cmd_pkg::cmd_byte_t rx_byte_i,
  input  logic                   rx_valid_i,
  spi_xfer_if.requester          xfer
);

  logic                   expect_data_q;
  logic                   start_q;
  slm_cmd_pkg::cmd_byte_t addr_slot_q;
  slm_cmd_pkg::cmd_byte_t data_slot_q;

  // odd/even byte toggle, 0 = waiting for address
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      expect_data_q <= 1'b0;
      start_q       <= 1'b0;
    end else begin
      start_q <= rx_valid_i && expect_data_q;
      if (rx_valid_i) expect_data_q <= ~expect_data_q;
    end
  end

  // every byte moves along the chain, data slot to address slot
  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i) begin
      addr_slot_q <= data_slot_q;
      data_slot_q <= rx_byte_i;
    end
  end

  assign xfer.start = start_q;
  assign xfer.frame = {addr_slot_q, data_slot_q};

endmodule

// ==== src/spi_master.sv ====
/*
  mode-0 spi master
  shifts the 16-bit frame out msb first and returns the last
  eight miso samples as the reply byte
*/

`timescale 1ns/1ns

module spi_master (
  input  logic          fpga_clk,
  input  logic          reset_all_cmd_w,
  spi_xfer_if.responder xfer,
  output logic          sen_o,
  output logic          sck_o,
  output logic          sdat_o,
  input  logic          sout_i
);

  // one count per sck half period over the frame
  typedef logic [$clog2(2 * slm_cmd_pkg::SPI_FRAME_BITS)-1:0] half_idx_t;

  link_timing_pkg::spi_state_t state_q;
  link_timing_pkg::baud_cnt_t  div_cnt_q;
  half_idx_t                   half_idx_q;
  logic                        launch;
  logic                        half_end;
  logic                        last_half;
  logic                        sck_rise;
  logic                        sck_fall;
  slm_cmd_pkg::spi_frame_t     mosi_shreg_q;
  slm_cmd_pkg::cmd_byte_t      miso_shreg_q;

  // start while busy is ignored
  assign launch    = !xfer.busy && xfer.start;
  assign half_end  = (state_q == link_timing_pkg::SPI_SHIFT) &&
                     (div_cnt_q ==
                      link_timing_pkg::baud_cnt_t'(link_timing_pkg::SPI_HALF_PERIOD - 1));
  assign last_half = half_idx_q == half_idx_t'(2 * slm_cmd_pkg::SPI_FRAME_BITS - 1);
  // edges about to happen on sck
  assign sck_rise  = half_end && !sck_o;
  assign sck_fall  = half_end && sck_o && !last_half;

  //////////////////////////////////////////////////
  // frame sequencing

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state_q          <= link_timing_pkg::SPI_IDLE;
      sen_o            <= 1'b1;
      sck_o            <= 1'b0;
      div_cnt_q        <= '0;
      half_idx_q       <= '0;
      xfer.reply_valid <= 1'b0;
    end else begin
      xfer.reply_valid <= 1'b0;
      if (launch) begin
        // sen low the cycle after start
        state_q    <= link_timing_pkg::SPI_SHIFT;
        sen_o      <= 1'b0;
        div_cnt_q  <= '0;
        half_idx_q <= '0;
      end else if (half_end) begin
        div_cnt_q  <= '0;
        half_idx_q <= half_idx_q + 1'b1;
        if (last_half) begin
          // 16th falling edge, close the frame
          state_q          <= link_timing_pkg::SPI_IDLE;
          sen_o            <= 1'b1;
          sck_o            <= 1'b0;
          xfer.reply_valid <= 1'b1;
        end else begin
          sck_o <= ~sck_o;
        end
      end else if (state_q == link_timing_pkg::SPI_SHIFT) begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // data shifters

  // mosi changes on sck falling, bit 15 ready as sen drops
  always_ff @(posedge fpga_clk) begin
    if (launch)
      mosi_shreg_q <= xfer.frame;
    else if (sck_fall)
      mosi_shreg_q <= {mosi_shreg_q[slm_cmd_pkg::SPI_FRAME_BITS-2:0], 1'b0};
  end

  // miso sampled on sck rising, only the last eight survive
  always_ff @(posedge fpga_clk) begin
    if (sck_rise)
      miso_shreg_q <= {miso_shreg_q[6:0], sout_i};
  end

  assign sdat_o     = mosi_shreg_q[slm_cmd_pkg::SPI_FRAME_BITS-1];
  assign xfer.reply = miso_shreg_q;
  assign xfer.busy  = state_q == link_timing_pkg::SPI_SHIFT;

endmodule

// ==== src/reply_queue.sv ====
/*
  reply queue
  four-entry byte fifo between spi replies and the uart transmitter,
  read first and start the transmitter one cycle later
*/

`timescale 1ns/1ns

module reply_queue (
  input  logic                   fpga_clk,
  input  logic                   reset_all_cmd_w,
  input  slm_cmd_pkg::cmd_byte_t wr_byte_i,
  input  logic                   wr_valid_i,
  input  logic                   tx_busy_i,
  output slm_cmd_pkg::cmd_byte_t tx_byte_o,
  output logic                   tx_start_o
);

  // entry count needs one more state than the depth
  typedef logic [$clog2(slm_cmd_pkg::REPLY_DEPTH + 1)-1:0] count_t;

  slm_cmd_pkg::cmd_byte_t mem_q [slm_cmd_pkg::REPLY_DEPTH];
  slm_cmd_pkg::reply_ptr_t wr_ptr_q;
  slm_cmd_pkg::reply_ptr_t rd_ptr_q;
  count_t                 count_q;
  logic                   wr_pend_q;
  slm_cmd_pkg::cmd_byte_t wr_byte_q;
  logic                   rd_pend_q;
  logic                   full;
  logic                   empty;
  logic                   wr_en;
  logic                   rd_en;

  assign full  = count_q == count_t'(slm_cmd_pkg::REPLY_DEPTH);
  assign empty = count_q == '0;
  // write lands the cycle after reply_valid, dropped when full
  assign wr_en = wr_pend_q && !full;
  // no second read while the previous start is still in flight
  assign rd_en = !empty && !tx_busy_i && !rd_pend_q;

  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q  <= '0;
      rd_ptr_q  <= '0;
      count_q   <= '0;
      wr_pend_q <= 1'b0;
      rd_pend_q <= 1'b0;
    end else begin
      wr_pend_q <= wr_valid_i;
      rd_pend_q <= rd_en;
      if (wr_en) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (rd_en) rd_ptr_q <= rd_ptr_q + 1'b1;
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage and output byte
  always_ff @(posedge fpga_clk) begin
    wr_byte_q <= wr_byte_i;
    if (wr_en) mem_q[wr_ptr_q] <= wr_byte_q;
    if (rd_en) tx_byte_o <= mem_q[rd_ptr_q];
  end

  // transmitter start one cycle after the read
  assign tx_start_o = rd_pend_q;

endmodule

// ==== src/bridge_top.sv ====
/*
  pc to display control bridge
  uart byte pairs become spi register writes, the miso byte of
  each write is echoed back to the pc over uart
*/

`timescale 1ns/1ns

module bridge_top (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  // pc uart
  input  logic uart_rx_i,
  output logic uart_tx_o,
  // display spi
  output logic spi_sen_o,
  output logic spi_sck_o,
  output logic spi_sdat_o,
  input  logic spi_sout_i
);

  //////////////////////////////////////////////////
  // internal links

  slm_cmd_pkg::cmd_byte_t rx_byte;
  logic                   rx_valid;
  slm_cmd_pkg::cmd_byte_t tx_byte;
  logic                   tx_start;
  logic                   tx_busy;

  spi_xfer_if xfer_if ();

  //////////////////////////////////////////////////
  // pc -> display

  uart_rx u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_byte_o       (rx_byte),
    .rx_valid_o      (rx_valid)
  );

  cmd_assembler u_cmd_assembler (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_byte_i       (rx_byte),
    .rx_valid_i      (rx_valid),
    .xfer            (xfer_if.requester)
  );

  spi_master u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .xfer            (xfer_if.responder),
    .sen_o           (spi_sen_o),
    .sck_o           (spi_sck_o),
    .sdat_o          (spi_sdat_o),
    .sout_i          (spi_sout_i)
  );

  //////////////////////////////////////////////////
  // display -> pc

  // reply byte queued, then drained when the transmitter is free
  reply_queue u_reply_queue (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .wr_byte_i       (xfer_if.reply),
    .wr_valid_i      (xfer_if.reply_valid),
    .tx_busy_i       (tx_busy),
    .tx_byte_o       (tx_byte),
    .tx_start_o      (tx_start)
  );

  uart_tx u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_byte_i       (tx_byte),
    .tx_start_i      (tx_start),
    .tx_busy_o       (tx_busy),
    .tx_serial_o     (uart_tx_o)
  );

endmodule

// ==== tb/bridge_properties.sv ====
/*
  bridge protocol assertions
  spi enable and clock rules, uart line idle level
*/

`timescale 1ns/1ns

module bridge_properties (
  input logic fpga_clk,
  input logic reset_all_cmd_w,
  input logic sen_i,
  input logic sck_i,
  input logic tx_busy_i,
  input logic tx_serial_i
);

  // failures seen so far, read back by the testbench top
  int         assert_fail_cnt = 0;
  logic [7:0] sen_low_cnt;

  // cycles spent with sen low in the current frame
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w || sen_i) sen_low_cnt <= '0;
    else sen_low_cnt <= sen_low_cnt + 1'b1;
  end

  sck_low_when_idle: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w) sen_i |-> !sck_i)
    else begin
      assert_fail_cnt++;
      $error("sck high while sen is high");
    end

  // 16 sck periods of 4 cycles
  sen_frame_length: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w) $rose(sen_i) |-> sen_low_cnt == 8'd64)
    else begin
      assert_fail_cnt++;
      $error("sen low for %0d cycles instead of 64", sen_low_cnt);
    end

  tx_line_idle_high: assert property (
    @(posedge fpga_clk) disable iff (reset_all_cmd_w) !tx_busy_i |-> tx_serial_i)
    else begin
      assert_fail_cnt++;
      $error("uart tx line low while transmitter idle");
    end

endmodule

// spi master and uart transmitter pins as seen at the bridge level
bind bridge_top bridge_properties u_props (
  .fpga_clk        (fpga_clk),
  .reset_all_cmd_w (reset_all_cmd_w),
  .sen_i           (spi_sen_o),
  .sck_i           (spi_sck_o),
  .tx_busy_i       (tx_busy),
  .tx_serial_i     (uart_tx_o)
);

// ==== tb/bridge_checker.sv ====
/*
  bridge checker
  decodes spi frames and uart replies at the pins and compares
  them in order with the expected queues
*/

`timescale 1ns/1ns

module bridge_checker (
  input logic fpga_clk,
  input logic reset_all_cmd_w,
  input logic spi_sen_i,
  input logic spi_sck_i,
  input logic spi_sdat_i,
  input logic uart_tx_i
);

  slm_cmd_pkg::spi_frame_t exp_frames [$];
  slm_cmd_pkg::cmd_byte_t  exp_replies [$];
  int frame_count  = 0;
  int reply_count  = 0;
  int spi_err_cnt  = 0;
  int uart_err_cnt = 0;
  int misc_err_cnt = 0;

  logic                    sck_prev;
  logic                    sen_prev;
  int                      rise_cnt;
  slm_cmd_pkg::spi_frame_t frame_sh;

  // one pair sent, one frame and one reply owed
  task automatic expect_pair(input slm_cmd_pkg::spi_frame_t frame,
                             input slm_cmd_pkg::cmd_byte_t reply);
    exp_frames.push_back(frame);
    exp_replies.push_back(reply);
  endtask

  // quiet lines before any uart input
  task automatic check_idle_lines(input int cycles);
    repeat (cycles) begin
      @(posedge fpga_clk);
      if (spi_sen_i !== 1'b1 || spi_sck_i !== 1'b0 || uart_tx_i !== 1'b1) begin
        misc_err_cnt++;
        $display("[FAIL] t=%0t idle lines sen=%b sck=%b tx=%b", $time,
                 spi_sen_i, spi_sck_i, uart_tx_i);
      end
    end
  endtask

  task automatic check_spi_frame(input slm_cmd_pkg::spi_frame_t got, input int rises);
    slm_cmd_pkg::spi_frame_t want;
    frame_count++;
    if (exp_frames.size() == 0) begin
      spi_err_cnt++;
      $display("[FAIL] t=%0t unexpected spi frame 0x%04h", $time, got);
    end else begin
      want = exp_frames.pop_front();
      if (got !== want || rises != slm_cmd_pkg::SPI_FRAME_BITS) begin
        spi_err_cnt++;
        $display("[FAIL] t=%0t spi frame 0x%04h with %0d sck pulses, expected 0x%04h",
                 $time, got, rises, want);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // spi side, edges found from sampled pins

  always @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      sck_prev <= 1'b0;
      sen_prev <= 1'b1;
      rise_cnt <= 0;
    end else begin
      sck_prev <= spi_sck_i;
      sen_prev <= spi_sen_i;
      if (!sen_prev && spi_sen_i) begin
        // sen back high, frame complete
        check_spi_frame(frame_sh, rise_cnt);
        rise_cnt <= 0;
      end else if (spi_sen_i === 1'b0 && !sck_prev && spi_sck_i) begin
        frame_sh <= {frame_sh[slm_cmd_pkg::SPI_FRAME_BITS-2:0], spi_sdat_i};
        rise_cnt <= rise_cnt + 1;
      end
    end
  end

  //////////////////////////////////////////////////
  // uart side, 8N1 lsb first

  task automatic decode_uart_frame();
    slm_cmd_pkg::cmd_byte_t got;
    slm_cmd_pkg::cmd_byte_t want;
    logic                   framing_ok;
    int                     i;
    got        = '0;
    framing_ok = 1'b1;
    // low seen one edge late, step to the start bit centre
    repeat (link_timing_pkg::CLKS_PER_BIT / 2 - 1) @(posedge fpga_clk);
    if (uart_tx_i !== 1'b0) framing_ok = 1'b0;
    for (i = 0; i < link_timing_pkg::UART_DATA_BITS; i++) begin
      repeat (link_timing_pkg::CLKS_PER_BIT) @(posedge fpga_clk);
      got[i] = uart_tx_i;
    end
    repeat (link_timing_pkg::CLKS_PER_BIT) @(posedge fpga_clk);
    if (uart_tx_i !== 1'b1) framing_ok = 1'b0;
    reply_count++;
    if (exp_replies.size() == 0) begin
      uart_err_cnt++;
      $display("[FAIL] t=%0t unexpected uart reply 0x%02h", $time, got);
    end else begin
      want = exp_replies.pop_front();
      if (got !== want || !framing_ok) begin
        uart_err_cnt++;
        $display("[FAIL] t=%0t uart reply 0x%02h framing_ok=%b, expected 0x%02h",
                 $time, got, framing_ok, want);
      end
    end
  endtask

  initial begin : uart_monitor
    forever begin
      @(posedge fpga_clk);
      if (!reset_all_cmd_w && uart_tx_i === 1'b0) decode_uart_frame();
    end
  end

  // nothing owed once the run is over
  task automatic final_check();
    if (exp_frames.size() != 0 || exp_replies.size() != 0) begin
      misc_err_cnt++;
      $display("run ended with %0d spi frames and %0d uart replies never seen",
               exp_frames.size(), exp_replies.size());
    end
  endtask

endmodule

// ==== tb/tb_bridge.sv ====
/*
  bridge testbench
  sends byte pairs over uart, loops mosi back to miso and
  lets the checker compare spi frames and uart replies
*/

`timescale 1ns/1ns

module tb_bridge;

  localparam int NUM_PAIRS      = 10;
  localparam int IDLE_CYCLES    = 100;
  // two reply frames of settle time at the end
  localparam int DRAIN_CYCLES   = 2 * 10 * link_timing_pkg::CLKS_PER_BIT;
  localparam int TIMEOUT_CYCLES = NUM_PAIRS * 2 * 10 * link_timing_pkg::CLKS_PER_BIT * 3;

  typedef struct packed {
    slm_cmd_pkg::cmd_byte_t addr;
    slm_cmd_pkg::cmd_byte_t data;
    logic [15:0]            gap;
    slm_cmd_pkg::cmd_byte_t exp_reply;
  } stim_entry_t;

  logic        fpga_clk;
  logic        reset_all_cmd_w;
  logic        uart_rx_i;
  logic        uart_tx_o;
  logic        spi_sen_o;
  logic        spi_sck_o;
  logic        spi_sdat_o;
  logic        spi_sout_i = 1'b0;
  logic        sck_prev_q = 1'b0;
  logic [31:0] lcg_state  = 32'd66936;
  int          cycle_cnt  = 0;
  stim_entry_t stim_tbl [NUM_PAIRS];

  bridge_top uut (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sen_o       (spi_sen_o),
    .spi_sck_o       (spi_sck_o),
    .spi_sdat_o      (spi_sdat_o),
    .spi_sout_i      (spi_sout_i)
  );

  bridge_checker chk (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_sen_i       (spi_sen_o),
    .spi_sck_i       (spi_sck_o),
    .spi_sdat_i      (spi_sdat_o),
    .uart_tx_i       (uart_tx_o)
  );

  initial begin
    fpga_clk = 1'b0;
    forever #50 fpga_clk = ~fpga_clk;
  end

  // display model, mosi registered on sck falling and fed back as miso
  always @(posedge fpga_clk) begin
    sck_prev_q <= spi_sck_o;
    if (sck_prev_q && !spi_sck_o) spi_sout_i <= spi_sdat_o;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  //////////////////////////////////////////////////
  // stimulus table

  task automatic build_table();
    int i;
    stim_tbl[0] = '{8'h12, 8'h34, 16'd0, 8'h34};
    // old multi-byte flag address, plain write now
    stim_tbl[1] = '{8'hbc, 8'ha5, 16'd0, 8'ha5};
    // lone address byte held back longer than a whole frame
    stim_tbl[2] = '{8'h00, 8'hff, 16'd400, 8'hff};
    stim_tbl[3] = '{8'hff, 8'h00, 16'd7, 8'h00};
    for (i = 4; i < NUM_PAIRS; i++) begin
      lcg_state = lcg_next(lcg_state);
      stim_tbl[i].addr = lcg_state[23:16];
      lcg_state = lcg_next(lcg_state);
      stim_tbl[i].data = lcg_state[23:16];
      stim_tbl[i].gap  = {11'd0, lcg_state[12:8]};
      // loopback returns the data byte
      stim_tbl[i].exp_reply = stim_tbl[i].data;
    end
  endtask

  //////////////////////////////////////////////////
  // uart driver

  task automatic drive_bit(input logic value);
    @(posedge fpga_clk);
    uart_rx_i <= value;
    repeat (link_timing_pkg::CLKS_PER_BIT - 1) @(posedge fpga_clk);
  endtask

  task automatic send_uart_byte(input slm_cmd_pkg::cmd_byte_t value);
    int i;
    drive_bit(1'b0);
    for (i = 0; i < link_timing_pkg::UART_DATA_BITS; i++) drive_bit(value[i]);
    drive_bit(1'b1);
  endtask

  function automatic int total_errors();
    return chk.spi_err_cnt + chk.uart_err_cnt + chk.misc_err_cnt + uut.u_props.assert_fail_cnt;
  endfunction

  task automatic print_counts();
    $display("summary: frames=%0d replies=%0d spi_err=%0d uart_err=%0d other_err=%0d assert_err=%0d",
             chk.frame_count, chk.reply_count, chk.spi_err_cnt, chk.uart_err_cnt,
             chk.misc_err_cnt, uut.u_props.assert_fail_cnt);
  endtask

  // run limit from the length of the byte traffic
  always @(posedge fpga_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, not all uart replies came back", cycle_cnt);
      print_counts();
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  initial begin : main_seq
    int p;
    reset_all_cmd_w <= 1'b1;
    uart_rx_i       <= 1'b1;
    build_table();
    repeat (5) @(posedge fpga_clk);
    reset_all_cmd_w <= 1'b0;
    chk.check_idle_lines(IDLE_CYCLES);
    for (p = 0; p < NUM_PAIRS; p++) begin
      send_uart_byte(stim_tbl[p].addr);
      repeat (stim_tbl[p].gap) @(posedge fpga_clk);
      send_uart_byte(stim_tbl[p].data);
      // owed only once the pair is complete
      chk.expect_pair({stim_tbl[p].addr, stim_tbl[p].data}, stim_tbl[p].exp_reply);
    end
    while (chk.reply_count < NUM_PAIRS) @(posedge fpga_clk);
    // catch any late extra frame or reply
    repeat (DRAIN_CYCLES) @(posedge fpga_clk);
    chk.final_check();
    print_counts();
    if (total_errors() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== bridge_top.f ====
src/link_timing_pkg.sv
src/slm_cmd_pkg.sv
src/spi_xfer_if.sv
src/uart_rx.sv
src/uart_tx.sv
src/cmd_assembler.sv
src/spi_master.sv
src/reply_queue.sv
src/bridge_top.sv
tb/bridge_properties.sv
tb/bridge_checker.sv
tb/tb_bridge.sv

// ==== Makefile ====
# verilator simulation of the uart to spi bridge

SIM      = verilator
SIMFLAGS = --binary --timing --assert -Wno-fatal
TOP      = tb_bridge
FILELIST = bridge_top.f
BUILD    = obj_dir
LOG      = sim.log
FAILMSG  = TEST RESULT: FAIL
PASSMSG  = TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
